/* filelist.f */
+incdir+logic
logic/console_pkg.sv
logic/ep_link_if.sv
logic/byte_ram.sv
logic/console_regs.sv
logic/session_dispatch.sv
logic/session_endpoint.sv
logic/capture_writer.sv
logic/sys_console.sv
tests/tb_clock.sv
tests/sys_console_tb.sv

/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= sys_console_tb
RTL_TOP    ?= sys_console
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --assert

COMMON_FLAGS = --timing --timescale $(TIMESCALE) -f $(FILELIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(COMMON_FLAGS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) $(COMMON_FLAGS) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/sys_console_tb.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module sys_console_tb;

	localparam real CLK_PERIOD = 40.0;
	localparam int  NUM_FRAMES = 12;
	localparam int  MAX_LEN    = 40;
	// every byte staged or read back over the whole run
	localparam int  TOTAL_BYTES = NUM_FRAMES * (2 * MAX_LEN + 1) + 2 * 17 + 5 + 260 + 255;
	localparam int  WATCHDOG_CYCLES = 8 * TOTAL_BYTES + 40 * (NUM_FRAMES + 6);

	logic       clk;
	logic       rst_i;
	logic [2:0] slave_address_i;
	logic       slave_read_i;
	logic       slave_write_i;
	logic [7:0] slave_writedata_i;
	logic [7:0] slave_readdata_o;

	int         seed;
	string      test_name;
	// model of the staging buffer and of the expected capture frame
	logic [7:0] staged [$];
	logic [7:0] frame [$];

	tb_clock #(.PERIOD(CLK_PERIOD)) clock_i (.clk_o(clk));

	sys_console sys_console_i (
		.clk               (clk),
		.rst_i             (rst_i),
		.slave_address_i   (slave_address_i),
		.slave_read_i      (slave_read_i),
		.slave_write_i     (slave_write_i),
		.slave_writedata_i (slave_writedata_i),
		.slave_readdata_o  (slave_readdata_o)
	);

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout after %0d cycles, the DUT never finished", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

	task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] got);
		assert (got === exp) else begin
			$display("** Error [%s] %s: expected %02h, actual %02h", test_name, what, exp, got);
			$display("ERRORS FOUND");
			$fatal(1, "check failed");
		end
	endtask

	// one bus cycle entered 2 ns after a rising edge
	task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
		slave_address_i   = addr;
		slave_writedata_i = data;
		slave_write_i     = 1'b1;
		@(posedge clk);
		#2;
		slave_write_i = 1'b0;
	endtask

	// data is valid one cycle after the read strobe
	task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
		slave_address_i = addr;
		slave_read_i    = 1'b1;
		@(posedge clk);
		#2;
		slave_read_i = 1'b0;
		data         = slave_readdata_o;
	endtask

	task automatic stage_byte(input logic [7:0] data);
		bus_write(console_pkg::REG_DATA, data);
		if (staged.size() < `CONSOLE_MAX_PAYLOAD) begin
			staged.push_back(data);
		end
	endtask

	task automatic send_cmd(input console_pkg::cmd_op_e op, input int ep);
		bus_write(console_pkg::REG_CMD, {2'(op), 4'b0000, 2'(ep)});
		if (op == console_pkg::CMD_CLEAR) begin
			staged.delete();
		end
	endtask

	task automatic wait_ready();
		logic [7:0] st;
		st = 8'h00;
		while (st[1] !== 1'b1 || st[0] !== 1'b0) begin
			bus_read(console_pkg::REG_STATUS, st);
		end
	endtask

	// expected frame is header then the staged payload
	task automatic read_frame(input int ep);
		logic [7:0] got;
		frame.delete();
		frame.push_back({`CONSOLE_HDR_MARK, 4'(ep)});
		foreach (staged[i]) begin
			frame.push_back(staged[i]);
		end
		staged.delete();
		wait_ready();
		bus_read(console_pkg::REG_LENGTH, got);
		check_value("frame length", 8'(frame.size()), got);
		foreach (frame[i]) begin
			bus_read(console_pkg::REG_CAPTURE, got);
			check_value("capture byte", frame[i], got);
		end
		// read index has wrapped, so ready is gone
		bus_read(console_pkg::REG_STATUS, got);
		check_value("status after read-back", 8'h00, got);
	endtask

	initial begin
		int         ep;
		int         other;
		int         len;
		logic [7:0] got;
		seed              = 93;
		rst_i             = 1'b1;
		slave_address_i   = 3'd0;
		slave_read_i      = 1'b0;
		slave_write_i     = 1'b0;
		slave_writedata_i = 8'h00;
		repeat (8) @(posedge clk);
		#2;
		rst_i = 1'b0;

		test_name = "reset";
		bus_read(console_pkg::REG_STATUS, got);
		check_value("status", 8'h00, got);
		bus_read(console_pkg::REG_LENGTH, got);
		check_value("length", 8'h00, got);

		test_name = "random frames";
		for (int f = 0; f < NUM_FRAMES; f++) begin
			ep  = $unsigned($random(seed)) % `CONSOLE_NUM_EP;
			len = 1 + $unsigned($random(seed)) % MAX_LEN;
			for (int i = 0; i < len; i++) begin
				stage_byte(8'($random(seed)));
			end
			send_cmd(console_pkg::CMD_SEND, ep);
			read_frame(ep);
		end

		test_name = "read wrap";
		bus_read(console_pkg::REG_CAPTURE, got);
		check_value("header after wrap", frame[0], got);

		test_name = "send while busy";
		ep    = $unsigned($random(seed)) % `CONSOLE_NUM_EP;
		other = (ep + 1) % `CONSOLE_NUM_EP;
		for (int i = 0; i < 16; i++) begin
			stage_byte(8'($random(seed)));
		end
		send_cmd(console_pkg::CMD_SEND, ep);
		got = 8'h00;
		while (got[0] !== 1'b1) begin
			bus_read(console_pkg::REG_STATUS, got);
		end
		// dropped while busy so the frame keeps the first endpoint
		send_cmd(console_pkg::CMD_SEND, other);
		read_frame(ep);

		test_name = "clear";
		for (int i = 0; i < 5; i++) begin
			stage_byte(8'($random(seed)));
		end
		send_cmd(console_pkg::CMD_CLEAR, 0);
		send_cmd(console_pkg::CMD_SEND, ep);
		repeat (10) @(posedge clk);
		#2;
		bus_read(console_pkg::REG_STATUS, got);
		check_value("status after empty send", 8'h00, got);

		test_name = "max payload";
		ep = $unsigned($random(seed)) % `CONSOLE_NUM_EP;
		for (int i = 0; i < 260; i++) begin
			stage_byte(8'($random(seed)));
		end
		send_cmd(console_pkg::CMD_SEND, ep);
		read_frame(ep);
		// length register holds after the read-back
		bus_read(console_pkg::REG_LENGTH, got);
		check_value("max frame length", 8'd255, got);

		$display("NO ERRORS");
		$finish;
	end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter real PERIOD = 40.0
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2.0) clk_o = ~clk_o;
	end

endmodule

/* logic/sys_console.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module sys_console (
	input  logic       clk,
	input  logic       rst_i,
	input  logic [2:0] slave_address_i,
	input  logic       slave_read_i,
	input  logic       slave_write_i,
	input  logic [7:0] slave_writedata_i,
	output logic [7:0] slave_readdata_o
);

	localparam int AW = `CONSOLE_ADDR_W;

	logic          stage_we;
	logic [AW-1:0] stage_wr_addr;
	logic [AW-1:0] stage_rd_addr;
	logic [AW-1:0] stage_addr;
	logic [7:0]    stage_data;
	logic [7:0]    stage_q;
	logic          cmd_valid;
	logic [7:0]    cmd_byte;
	logic [AW-1:0] stage_len;
	logic          busy;

	logic          cap_we;
	logic [AW-1:0] cap_wr_addr;
	logic [AW-1:0] cap_rd_addr;
	logic [AW-1:0] cap_addr;
	logic [7:0]    cap_data;
	logic [7:0]    cap_q;
	logic          frame_done;
	logic [AW-1:0] frame_len;

	logic [`CONSOLE_NUM_EP-1:0] ep_fifo_write;
	logic [7:0]                 ep_message [`CONSOLE_NUM_EP];
	logic [`CONSOLE_NUM_EP-1:0] ep_end_msg;

	ep_link_if link [`CONSOLE_NUM_EP] ();

	// host writes take the staging port, otherwise the dispatcher reads
	assign stage_addr = stage_we ? stage_wr_addr : stage_rd_addr;
	// frame writes take the capture port over host reads
	assign cap_addr   = cap_we ? cap_wr_addr : cap_rd_addr;

	console_regs regs_i (
		.clk               (clk),
		.rst_i             (rst_i),
		.slave_address_i   (slave_address_i),
		.slave_read_i      (slave_read_i),
		.slave_write_i     (slave_write_i),
		.slave_writedata_i (slave_writedata_i),
		.slave_readdata_o  (slave_readdata_o),
		.stage_we_o        (stage_we),
		.stage_addr_o      (stage_wr_addr),
		.stage_data_o      (stage_data),
		.cmd_valid_o       (cmd_valid),
		.cmd_byte_o        (cmd_byte),
		.stage_len_o       (stage_len),
		.busy_i            (busy),
		.frame_done_i      (frame_done),
		.frame_len_i       (frame_len),
		.cap_rd_addr_o     (cap_rd_addr),
		.cap_q_i           (cap_q)
	);

	byte_ram #(.ADDR_W(AW), .DATA_W(8)) stage_ram_i (
		.clk    (clk),
		.we_i   (stage_we),
		.addr_i (stage_addr),
		.data_i (stage_data),
		.q_o    (stage_q)
	);

	session_dispatch dispatch_i (
		.clk             (clk),
		.rst_i           (rst_i),
		.cmd_valid_i     (cmd_valid),
		.cmd_byte_i      (cmd_byte),
		.stage_len_i     (stage_len),
		.stage_rd_addr_o (stage_rd_addr),
		.stage_q_i       (stage_q),
		.busy_o          (busy),
		.link_o          (link)
	);

	for (genvar g = 0; g < `CONSOLE_NUM_EP; g++) begin : g_ep
		session_endpoint #(.EP_ID(g)) endpoint_i (
			.clk          (clk),
			.rst_i        (rst_i),
			.link_i       (link[g]),
			.fifo_write_o (ep_fifo_write[g]),
			.message_o    (ep_message[g]),
			.end_msg_o    (ep_end_msg[g])
		);
	end

	capture_writer capture_i (
		.clk          (clk),
		.rst_i        (rst_i),
		.fifo_write_i (ep_fifo_write),
		.message_i    (ep_message),
		.end_msg_i    (ep_end_msg),
		.cap_we_o     (cap_we),
		.cap_addr_o   (cap_wr_addr),
		.cap_data_o   (cap_data),
		.frame_done_o (frame_done),
		.frame_len_o  (frame_len)
	);

	byte_ram #(.ADDR_W(AW), .DATA_W(8)) cap_ram_i (
		.clk    (clk),
		.we_i   (cap_we),
		.addr_i (cap_addr),
		.data_i (cap_data),
		.q_o    (cap_q)
	);

endmodule

/* logic/capture_writer.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module capture_writer (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic [`CONSOLE_NUM_EP-1:0] fifo_write_i,
	input  logic [7:0]                 message_i [`CONSOLE_NUM_EP],
	input  logic [`CONSOLE_NUM_EP-1:0] end_msg_i,
	output logic                       cap_we_o,
	output logic [`CONSOLE_ADDR_W-1:0] cap_addr_o,
	output logic [7:0]                 cap_data_o,
	output logic                       frame_done_o,
	output logic [`CONSOLE_ADDR_W-1:0] frame_len_o
);

	localparam int AW = `CONSOLE_ADDR_W;

	logic [AW-1:0] wr_idx;
	logic [7:0]    sel_msg;
	logic          sel_end;

	// lowest endpoint index wins
	always_comb begin
		sel_msg = '0;
		sel_end = 1'b0;
		for (int i = `CONSOLE_NUM_EP - 1; i >= 0; i--) begin
			if (fifo_write_i[i]) begin
				sel_msg = message_i[i];
				sel_end = end_msg_i[i];
			end
		end
	end

	assign cap_we_o   = |fifo_write_i;
	assign cap_addr_o = wr_idx;
	assign cap_data_o = sel_msg;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_idx       <= '0;
			frame_done_o <= 1'b0;
			frame_len_o  <= '0;
		end else begin
			frame_done_o <= 1'b0;
			if (cap_we_o) begin
				if (sel_end) begin
					// length counts the header byte
					frame_len_o  <= wr_idx + AW'(1);
					wr_idx       <= '0;
					frame_done_o <= 1'b1;
				end else begin
					wr_idx <= wr_idx + AW'(1);
				end
			end
		end
	end

endmodule

/* logic/session_endpoint.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module session_endpoint #(
	parameter int EP_ID = 0
) (
	input  logic             clk,
	input  logic             rst_i,
	ep_link_if.endpoint      link_i,
	output logic             fifo_write_o,
	output logic [7:0]       message_o,
	output logic             end_msg_o
);

	localparam logic [7:0] HEADER = {`CONSOLE_HDR_MARK, 4'(EP_ID)};

	console_pkg::ep_state_e state;

	assign link_i.busy = (state != console_pkg::EP_IDLE);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state        <= console_pkg::EP_IDLE;
			fifo_write_o <= 1'b0;
			end_msg_o    <= 1'b0;
		end else begin
			fifo_write_o <= 1'b0;
			end_msg_o    <= 1'b0;
			case (state)
				console_pkg::EP_IDLE: begin
					// header goes out right after start
					if (link_i.start) begin
						fifo_write_o <= 1'b1;
						state        <= console_pkg::EP_HEADER;
					end
				end
				console_pkg::EP_HEADER, console_pkg::EP_CONNECTED: begin
					state <= console_pkg::EP_CONNECTED;
					if (link_i.new_message) begin
						fifo_write_o <= 1'b1;
						if (link_i.last) begin
							end_msg_o <= 1'b1;
							state     <= console_pkg::EP_IDLE;
						end
					end
				end
				default: state <= console_pkg::EP_IDLE;
			endcase
		end
	end

	// output byte, header while idle, payload once connected
	always_ff @(posedge clk) begin
		if (state == console_pkg::EP_IDLE) begin
			message_o <= HEADER;
		end else if (link_i.new_message) begin
			message_o <= link_i.message;
		end
	end

endmodule

/* logic/session_dispatch.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module session_dispatch (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       cmd_valid_i,
	input  logic [7:0]                 cmd_byte_i,
	input  logic [`CONSOLE_ADDR_W-1:0] stage_len_i,
	output logic [`CONSOLE_ADDR_W-1:0] stage_rd_addr_o,
	input  logic [7:0]                 stage_q_i,
	output logic                       busy_o,
	ep_link_if.dispatcher              link_o [`CONSOLE_NUM_EP]
);

	localparam int AW   = `CONSOLE_ADDR_W;
	localparam int EP_W = $clog2(`CONSOLE_NUM_EP);

	console_pkg::disp_state_e   state;
	console_pkg::cmd_op_e       op;
	logic                       start_q;
	logic [EP_W-1:0]            ep_sel;
	logic [AW-1:0]              remain;
	logic                       streaming;
	logic                       last_byte;
	logic [`CONSOLE_NUM_EP-1:0] ep_busy;

	assign op        = console_pkg::cmd_op_e'(cmd_byte_i[7:6]);
	assign streaming = (state == console_pkg::DS_STREAM);
	assign last_byte = streaming && (remain == AW'(1));

	// busy until the endpoint has closed its session too
	assign busy_o = (state != console_pkg::DS_IDLE) || (|ep_busy);

	for (genvar g = 0; g < `CONSOLE_NUM_EP; g++) begin : g_link
		assign link_o[g].start       = start_q && (ep_sel == EP_W'(g));
		assign link_o[g].new_message = streaming && (ep_sel == EP_W'(g));
		assign link_o[g].message     = stage_q_i;
		assign link_o[g].last        = last_byte && (ep_sel == EP_W'(g));
		assign ep_busy[g]            = link_o[g].busy;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state   <= console_pkg::DS_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= 1'b0;
			case (state)
				console_pkg::DS_IDLE: begin
					if (cmd_valid_i && op == console_pkg::CMD_SEND &&
					    stage_len_i != '0 && !busy_o) begin
						start_q <= 1'b1;
						state   <= console_pkg::DS_FETCH;
					end
				end
				// one cycle for the staging RAM read latency
				console_pkg::DS_FETCH: state <= console_pkg::DS_STREAM;
				console_pkg::DS_STREAM: begin
					if (last_byte) begin
						state <= console_pkg::DS_IDLE;
					end
				end
				default: state <= console_pkg::DS_IDLE;
			endcase
		end
	end

	// command capture and read pointer
	always_ff @(posedge clk) begin
		if (state == console_pkg::DS_IDLE) begin
			ep_sel          <= cmd_byte_i[EP_W-1:0];
			remain          <= stage_len_i;
			stage_rd_addr_o <= '0;
		end else begin
			stage_rd_addr_o <= stage_rd_addr_o + AW'(1);
			if (streaming) begin
				remain <= remain - AW'(1);
			end
		end
	end

endmodule

/* logic/console_regs.sv */
`timescale 1ns/1ps
`include "console_cfg.svh"

module console_regs (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic [2:0]                 slave_address_i,
	input  logic                       slave_read_i,
	input  logic                       slave_write_i,
	input  logic [7:0]                 slave_writedata_i,
	output logic [7:0]                 slave_readdata_o,
	output logic                       stage_we_o,
	output logic [`CONSOLE_ADDR_W-1:0] stage_addr_o,
	output logic [7:0]                 stage_data_o,
	output logic                       cmd_valid_o,
	output logic [7:0]                 cmd_byte_o,
	output logic [`CONSOLE_ADDR_W-1:0] stage_len_o,
	input  logic                       busy_i,
	input  logic                       frame_done_i,
	input  logic [`CONSOLE_ADDR_W-1:0] frame_len_i,
	output logic [`CONSOLE_ADDR_W-1:0] cap_rd_addr_o,
	input  logic [7:0]                 cap_q_i
);

	localparam int AW = `CONSOLE_ADDR_W;

	console_pkg::reg_addr_e addr;
	console_pkg::cmd_op_e   op;
	logic [AW-1:0]          stage_idx;
	logic [AW-1:0]          rd_idx;
	logic                   ready;
	logic                   sel_cap;
	logic [7:0]             reg_q;
	logic                   rd_cap;
	logic                   wr_cmd;

	assign addr   = console_pkg::reg_addr_e'(slave_address_i);
	assign op     = console_pkg::cmd_op_e'(slave_writedata_i[7:6]);
	assign rd_cap = slave_read_i && (addr == console_pkg::REG_CAPTURE);
	assign wr_cmd = slave_write_i && (addr == console_pkg::REG_CMD);

	// staging writes stop at the payload limit
	assign stage_we_o   = slave_write_i && (addr == console_pkg::REG_DATA) &&
	                      (stage_idx < AW'(`CONSOLE_MAX_PAYLOAD));
	assign stage_addr_o = stage_idx;
	assign stage_data_o = slave_writedata_i;

	assign cmd_valid_o = wr_cmd;
	assign cmd_byte_o  = slave_writedata_i;
	assign stage_len_o = stage_idx;

	assign cap_rd_addr_o    = rd_idx;
	assign slave_readdata_o = sel_cap ? cap_q_i : reg_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			stage_idx <= '0;
			rd_idx    <= '0;
			ready     <= 1'b0;
			sel_cap   <= 1'b0;
			reg_q     <= '0;
		end else begin
			if ((wr_cmd && op == console_pkg::CMD_CLEAR) || frame_done_i) begin
				stage_idx <= '0;
			end else if (stage_we_o) begin
				stage_idx <= stage_idx + AW'(1);
			end

			// a new frame restarts the read-back from the header
			if (frame_done_i) begin
				rd_idx <= '0;
				ready  <= 1'b1;
			end else if (rd_cap) begin
				if (rd_idx + AW'(1) == frame_len_i) begin
					rd_idx <= '0;
					ready  <= 1'b0;
				end else begin
					rd_idx <= rd_idx + AW'(1);
				end
			end

			sel_cap <= rd_cap;
			reg_q   <= '0;
			if (slave_read_i && addr == console_pkg::REG_STATUS) begin
				reg_q <= {6'b0, ready, busy_i};
			end else if (slave_read_i && addr == console_pkg::REG_LENGTH) begin
				reg_q <= 8'(frame_len_i);
			end
		end
	end

endmodule

/* logic/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram #(
	parameter int ADDR_W = 8,
	parameter int DATA_W = 8
) (
	input  logic              clk,
	input  logic              we_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] data_i,
	output logic [DATA_W-1:0] q_o
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// read returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (we_i) begin
			mem[addr_i] <= data_i;
		end
		q_o <= mem[addr_i];
	end

endmodule

/* logic/ep_link_if.sv */
`timescale 1ns/1ps

interface ep_link_if;
	logic       start;
	logic       new_message;
	logic [7:0] message;
	logic       last;
	logic       busy;

	modport dispatcher (
		output start, new_message, message, last,
		input  busy
	);

	modport endpoint (
		input  start, new_message, message, last,
		output busy
	);
endinterface

/* logic/console_pkg.sv */
package console_pkg;

	// command byte bits 7:6
	typedef enum logic [1:0] {
		CMD_NOP   = 2'd0,
		CMD_SEND  = 2'd1,
		CMD_CLEAR = 2'd2
	} cmd_op_e;

	typedef enum logic [2:0] {
		REG_DATA    = 3'd0,
		REG_CAPTURE = 3'd1,
		REG_CMD     = 3'd2,
		REG_STATUS  = 3'd3,
		REG_LENGTH  = 3'd4
	} reg_addr_e;

	typedef enum logic [1:0] {
		EP_IDLE,
		EP_HEADER,
		EP_CONNECTED
	} ep_state_e;

	typedef enum logic [1:0] {
		DS_IDLE,
		DS_FETCH,
		DS_STREAM
	} disp_state_e;

endpackage

/* logic/console_cfg.svh */
`ifndef CONSOLE_CFG_SVH
`define CONSOLE_CFG_SVH

// buffer address width, 256 bytes per buffer
`define CONSOLE_ADDR_W 8

// number of session endpoints
`define CONSOLE_NUM_EP 4

// staging writes beyond this are dropped
`define CONSOLE_MAX_PAYLOAD 254

// upper nibble of every header byte
`define CONSOLE_HDR_MARK 4'hA

`endif
